// File: project.f
design/steer_pkg.sv
design/pc_select.sv
design/load_return_mux.sv
design/operand_forward.sv
design/pipeline_steer.sv
verif/pipeline_steer_assert.sv
verif/tb_pipeline_steer.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator; a failed build or an aborted run counts as failure.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_pipeline_steer -f project.f > build.log 2>&1 &&
    ./obj_dir/Vtb_pipeline_steer > sim.log 2>&1 ||
    echo "CHECKS FAILED" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

// File: verif/tb_pipeline_steer.sv
module tb_pipeline_steer;

    logic                    clk;
    logic                    reset_i;
    logic                    stall_i;
    logic                    branch_fetch_i;
    logic                    predict_taken_i;
    logic [31:0]             fetch_target_i;
    logic                    jump_i;
    logic [31:0]             jump_target_i;
    steer_pkg::resolve_t     resolve_i;
    steer_pkg::load_req_t    ld_req_i;
    steer_pkg::read_data_t   rd_data_i;
    steer_pkg::operand_src_t ops_i;
    logic [31:0]             pc_o;
    logic                    flush_o;
    logic [31:0]             wb_data_o;
    logic                    wb_valid_o;
    logic [31:0]             alu_a_o;
    logic [31:0]             alu_b_o;

    logic [31:0]          lfsr_state;
    logic [31:0]          m_pc;
    logic                 m_pred;              // Prediction of the branch in flight.
    logic [31:0]          m_fall;
    steer_pkg::load_req_t m_req;               // Request of the previous cycle.
    string                test_name;
    int                   test_errors;
    int                   total_errors;
    int                   check_count;
    int                   test_count;
    bit                   timed_out;

    pipeline_steer DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] value;
        value = 32'b0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], rand_bit()};
        end
        return value;
    endfunction

    function automatic logic [31:0] aligned_target();
        logic [31:0] w;
        w = rand_word(30);
        return {w[29:0], 2'b00};
    endfunction

    function automatic steer_pkg::read_data_t random_read_data();
        steer_pkg::read_data_t rd;
        rd.dmem = rand_word(32);
        rd.bios = rand_word(32);
        rd.uart = rand_word(32);
        rd.conv = rand_word(32);
        return rd;
    endfunction

    function automatic logic [31:0] random_load_addr();
        logic [2:0]  pick;
        logic [1:0]  which;
        logic [31:0] low;
        pick  = {rand_bit(), rand_bit(), rand_bit()};
        which = {rand_bit(), rand_bit()};
        low   = rand_word(28);
        case (pick)
            3'd0: return {steer_pkg::REGION_DMEM_A, low[27:0]};
            3'd1: return {steer_pkg::REGION_DMEM_B, low[27:0]};
            3'd2: return {steer_pkg::REGION_BIOS, low[27:0]};
            3'd3: begin
                case (which)
                    2'd0: return steer_pkg::UART_CTRL_ADDR;
                    2'd1: return steer_pkg::UART_RX_ADDR;
                    2'd2: return steer_pkg::UART_CYCLE_ADDR;
                    default: return steer_pkg::UART_INST_ADDR;
                endcase
            end
            3'd4: return steer_pkg::CONV_READ_ADDR;
            3'd5: return {28'h8000_000, low[3:0]};   // Near the UART block.
            default: return rand_word(32);
        endcase
    endfunction

    // Address map decode, one cycle behind the request.
    function automatic logic [31:0] expected_load_word(input steer_pkg::load_req_t req,
                                                      input steer_pkg::read_data_t rd);
        logic [3:0] top;
        top = req.addr[31:28];
        if (!req.valid) return 32'b0;
        if (req.kind == steer_pkg::LD_MEM) begin
            if (top == steer_pkg::REGION_DMEM_A || top == steer_pkg::REGION_DMEM_B) return rd.dmem;
            if (top == steer_pkg::REGION_BIOS) return rd.bios;
        end else if (req.kind == steer_pkg::LD_IO) begin
            if (req.addr inside {steer_pkg::UART_CTRL_ADDR, steer_pkg::UART_RX_ADDR,
                                 steer_pkg::UART_CYCLE_ADDR, steer_pkg::UART_INST_ADDR}) begin
                return rd.uart;
            end
            if (req.addr == steer_pkg::CONV_READ_ADDR) return rd.conv;
        end
        return 32'b0;
    endfunction

    function automatic logic [31:0] expected_operand(input steer_pkg::fwd_sel_e code,
                                                    input logic [31:0] reg_word,
                                                    input logic [31:0] wb_word,
                                                    input logic [31:0] alt_word);
        if (code == steer_pkg::FWD_REG) return reg_word;
        if (code == steer_pkg::FWD_WB) return wb_word;
        if (code == steer_pkg::FWD_ALT) return alt_word;
        return 32'b0;
    endfunction

    task automatic compare_word(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            test_errors++;
            $display("** Error: %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic verify_bit(input string what, input bit expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            test_errors++;
            $display("** Error: %s %s expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic drive_idle();
        stall_i         <= 1'b0;
        branch_fetch_i  <= 1'b0;
        predict_taken_i <= 1'b0;
        fetch_target_i  <= 32'b0;
        jump_i          <= 1'b0;
        jump_target_i   <= 32'b0;
        resolve_i       <= '0;
        ld_req_i        <= '0;
        rd_data_i       <= '0;
        ops_i           <= '0;
    endtask

    // Checks this cycle's outputs, then steps the model across the next edge.
    task automatic evaluate_cycle();
        logic        exp_flush;
        logic [31:0] next_pc;
        exp_flush = resolve_i.valid && (resolve_i.taken != m_pred);
        compare_word("pc_o", m_pc, pc_o);
        verify_bit("flush_o", exp_flush, flush_o);
        verify_bit("wb_valid_o", m_req.valid, wb_valid_o);
        compare_word("wb_data_o", expected_load_word(m_req, rd_data_i), wb_data_o);
        compare_word("alu_a_o", expected_operand(ops_i.sel_a, ops_i.rs1, ops_i.wb, ops_i.pc),
                     alu_a_o);
        compare_word("alu_b_o", expected_operand(ops_i.sel_b, ops_i.rs2, ops_i.wb, ops_i.imm),
                     alu_b_o);
        if (exp_flush) begin
            next_pc = resolve_i.taken ? resolve_i.target : m_fall;
        end else if (stall_i) begin
            next_pc = m_pc;
        end else if (jump_i) begin
            next_pc = jump_target_i;
        end else if (branch_fetch_i && predict_taken_i) begin
            next_pc = fetch_target_i;
        end else begin
            next_pc = m_pc + 32'd4;
        end
        if (!stall_i) begin
            m_pred = branch_fetch_i && predict_taken_i;
            m_fall = m_pc + 32'd4;
        end
        m_pc  = next_pc;
        m_req = ld_req_i;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("Test %s done with %0d errors", test_name, test_errors);
        total_errors += test_errors;
        test_count++;
    endtask

    task automatic single_load_wait();
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        @(posedge clk);
        drive_idle();
        ld_req_i.valid <= 1'b1;
        ld_req_i.kind  <= steer_pkg::LD_MEM;
        ld_req_i.addr  <= {steer_pkg::REGION_BIOS, 28'h000_0040};
        @(negedge clk);
        evaluate_cycle();
        while (!seen && cycles < 8) begin
            @(posedge clk);
            drive_idle();
            rd_data_i <= random_read_data();
            @(negedge clk);
            evaluate_cycle();
            cycles++;
            seen = wb_valid_o;
        end
        if (!seen) begin
            timed_out = 1'b1;
            $display("Timeout: wb_valid_o never rose after a load request");
        end else if (cycles != 1) begin
            test_errors++;
            $display("Load data came back after %0d cycles instead of one", cycles);
        end
    endtask

    initial begin
        lfsr_state      = 32'ha7fc;
        reset_i         = 1'b1;
        stall_i         = 1'b0;
        branch_fetch_i  = 1'b0;
        predict_taken_i = 1'b0;
        fetch_target_i  = 32'b0;
        jump_i          = 1'b0;
        jump_target_i   = 32'b0;
        resolve_i       = '0;
        ld_req_i        = '0;
        rd_data_i       = '0;
        ops_i           = '0;
        m_pc            = steer_pkg::RESET_PC;
        m_pred          = 1'b0;
        m_fall          = 32'b0;
        m_req           = '0;
        total_errors    = 0;
        check_count     = 0;
        test_count      = 0;
        timed_out       = 1'b0;

        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        start_test("reset");
        @(negedge clk);
        evaluate_cycle();
        finish_test();

        start_test("sequential_fetch");
        for (int i = 0; i < 200; i++) begin
            @(posedge clk);
            drive_idle();
            stall_i         <= (rand_word(2) == 32'd0);
            jump_i          <= (rand_word(2) == 32'd0);
            jump_target_i   <= aligned_target();
            branch_fetch_i  <= (rand_word(2) == 32'd0);
            predict_taken_i <= rand_bit();
            fetch_target_i  <= aligned_target();
            @(negedge clk);
            evaluate_cycle();
        end
        finish_test();

        start_test("branch_predict");
        for (int i = 0; i < 100; i++) begin
            @(posedge clk);
            drive_idle();
            branch_fetch_i  <= 1'b1;
            predict_taken_i <= rand_bit();
            fetch_target_i  <= aligned_target();
            @(negedge clk);
            evaluate_cycle();
            @(posedge clk);
            drive_idle();
            resolve_i.valid  <= 1'b1;
            resolve_i.taken  <= rand_bit();
            resolve_i.target <= aligned_target();
            jump_i           <= rand_bit();     // Loses to a mispredict.
            jump_target_i    <= aligned_target();
            @(negedge clk);
            evaluate_cycle();
        end
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        evaluate_cycle();
        finish_test();

        start_test("load_routing");
        for (int i = 0; i < 300; i++) begin
            @(posedge clk);
            drive_idle();
            ld_req_i.valid <= (rand_word(2) != 32'd0);
            ld_req_i.kind  <= steer_pkg::ld_kind_e'({rand_bit(), rand_bit()});
            ld_req_i.addr  <= random_load_addr();
            rd_data_i      <= random_read_data();
            @(negedge clk);
            evaluate_cycle();
        end
        single_load_wait();
        finish_test();

        start_test("operand_forward");
        for (int i = 0; i < 200; i++) begin
            @(posedge clk);
            drive_idle();
            ops_i.rs1   <= rand_word(32);
            ops_i.rs2   <= rand_word(32);
            ops_i.wb    <= rand_word(32);
            ops_i.pc    <= rand_word(32);
            ops_i.imm   <= rand_word(32);
            ops_i.sel_a <= steer_pkg::fwd_sel_e'({rand_bit(), rand_bit()});
            ops_i.sel_b <= steer_pkg::fwd_sel_e'({rand_bit(), rand_bit()});
            @(negedge clk);
            evaluate_cycle();
        end
        finish_test();

        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/pipeline_steer_assert.sv
module pipeline_steer_assert (
    input logic                 clk,
    input logic                 reset_i,
    input steer_pkg::load_req_t ld_req_i,
    input steer_pkg::resolve_t  resolve_i,
    input logic [31:0]          pc_i,
    input logic                 flush_i,
    input logic                 wb_valid_i
);

    // Load data only comes back the cycle after a request.
    wb_after_request: assert property (
        @(posedge clk) disable iff (reset_i)
        wb_valid_i |-> $past(ld_req_i.valid)
    ) else $error("wb_valid_o high without a request in the previous cycle");

    flush_needs_resolve: assert property (
        @(posedge clk) disable iff (reset_i)
        flush_i |-> resolve_i.valid
    ) else $error("flush_o high without a resolving branch");

    pc_after_reset: assert property (
        @(posedge clk)
        $fell(reset_i) |-> (pc_i == steer_pkg::RESET_PC)
    ) else $error("pc_o is not the reset address after reset");

endmodule

bind pipeline_steer pipeline_steer_assert u_steer_assert (
    .clk        (clk),
    .reset_i    (reset_i),
    .ld_req_i   (ld_req_i),
    .resolve_i  (resolve_i),
    .pc_i       (pc_o),
    .flush_i    (flush_o),
    .wb_valid_i (wb_valid_o)
);

// File: design/pipeline_steer.sv
module pipeline_steer (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  logic                    branch_fetch_i,
    input  logic                    predict_taken_i,
    input  logic [31:0]             fetch_target_i,
    input  logic                    jump_i,
    input  logic [31:0]             jump_target_i,
    input  steer_pkg::resolve_t     resolve_i,
    input  steer_pkg::load_req_t    ld_req_i,
    input  steer_pkg::read_data_t   rd_data_i,
    input  steer_pkg::operand_src_t ops_i,
    output logic [31:0]             pc_o,
    output logic                    flush_o,
    output logic [31:0]             wb_data_o,
    output logic                    wb_valid_o,
    output logic [31:0]             alu_a_o,
    output logic [31:0]             alu_b_o
);

    pc_select u_pc_select (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_i         (stall_i),
        .branch_fetch_i  (branch_fetch_i),
        .predict_taken_i (predict_taken_i),
        .fetch_target_i  (fetch_target_i),
        .jump_i          (jump_i),
        .jump_target_i   (jump_target_i),
        .resolve_i       (resolve_i),
        .pc_o            (pc_o),
        .flush_o         (flush_o)
    );

    load_return_mux u_load_return_mux (
        .clk        (clk),
        .reset_i    (reset_i),
        .ld_req_i   (ld_req_i),
        .rd_data_i  (rd_data_i),
        .wb_data_o  (wb_data_o),
        .wb_valid_o (wb_valid_o)
    );

    // Execute stage operands.
    operand_forward u_operand_forward (
        .ops_i   (ops_i),
        .alu_a_o (alu_a_o),
        .alu_b_o (alu_b_o)
    );

endmodule

// File: design/operand_forward.sv
module operand_forward (
    input  steer_pkg::operand_src_t ops_i,
    output logic [31:0]             alu_a_o,
    output logic [31:0]             alu_b_o
);

    // Same rule on both sides, only the ALT source differs.
    function automatic logic [31:0] pick_operand(
        input steer_pkg::fwd_sel_e sel,
        input logic [31:0]         reg_val,
        input logic [31:0]         wb_val,
        input logic [31:0]         alt_val
    );
        logic [31:0] result;
        case (sel)
            steer_pkg::FWD_REG: result = reg_val;
            steer_pkg::FWD_WB:  result = wb_val;     // Bypass from writeback.
            steer_pkg::FWD_ALT: result = alt_val;
            default:            result = 32'b0;      // Spare code.
        endcase
        return result;
    endfunction

    assign alu_a_o = pick_operand(ops_i.sel_a, ops_i.rs1, ops_i.wb, ops_i.pc);
    assign alu_b_o = pick_operand(ops_i.sel_b, ops_i.rs2, ops_i.wb, ops_i.imm);

endmodule

// File: design/load_return_mux.sv
module load_return_mux (
    input  logic                  clk,
    input  logic                  reset_i,
    input  steer_pkg::load_req_t  ld_req_i,
    input  steer_pkg::read_data_t rd_data_i,
    output logic [31:0]           wb_data_o,
    output logic                  wb_valid_o
);

    logic [3:0]          region;
    logic                is_uart;
    steer_pkg::ret_src_e src_d;
    steer_pkg::ret_src_e src_q;
    logic                valid_q;

    assign region  = ld_req_i.addr[31:28];
    assign is_uart = (ld_req_i.addr == steer_pkg::UART_CTRL_ADDR)  ||
                     (ld_req_i.addr == steer_pkg::UART_RX_ADDR)    ||
                     (ld_req_i.addr == steer_pkg::UART_CYCLE_ADDR) ||
                     (ld_req_i.addr == steer_pkg::UART_INST_ADDR);

    always_comb begin
        src_d = steer_pkg::RET_NONE;
        case (ld_req_i.kind)
            steer_pkg::LD_MEM: begin
                if (region == steer_pkg::REGION_DMEM_A || region == steer_pkg::REGION_DMEM_B) begin
                    src_d = steer_pkg::RET_DMEM;
                end else if (region == steer_pkg::REGION_BIOS) begin
                    src_d = steer_pkg::RET_BIOS;
                end
            end
            steer_pkg::LD_IO: begin
                if (is_uart) begin
                    src_d = steer_pkg::RET_UART;
                end else if (ld_req_i.addr == steer_pkg::CONV_READ_ADDR) begin
                    src_d = steer_pkg::RET_CONV;
                end
            end
            default: src_d = steer_pkg::RET_NONE;   // Unknown kind reads zero.
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            src_q   <= steer_pkg::RET_NONE;
        end else begin
            valid_q <= ld_req_i.valid;
            src_q   <= ld_req_i.valid ? src_d : steer_pkg::RET_NONE;
        end
    end

    // Memories answer one cycle after the request.
    always_comb begin
        case (src_q)
            steer_pkg::RET_DMEM: wb_data_o = rd_data_i.dmem;
            steer_pkg::RET_BIOS: wb_data_o = rd_data_i.bios;
            steer_pkg::RET_UART: wb_data_o = rd_data_i.uart;
            steer_pkg::RET_CONV: wb_data_o = rd_data_i.conv;
            default:             wb_data_o = 32'b0;
        endcase
    end

    assign wb_valid_o = valid_q;

endmodule

// File: design/pc_select.sv
module pc_select (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                stall_i,
    input  logic                branch_fetch_i,
    input  logic                predict_taken_i,
    input  logic [31:0]         fetch_target_i,
    input  logic                jump_i,
    input  logic [31:0]         jump_target_i,
    input  steer_pkg::resolve_t resolve_i,
    output logic [31:0]         pc_o,
    output logic                flush_o
);

    logic [31:0] pc_q;
    logic [31:0] pc_next;
    logic [31:0] pc_plus4;
    logic        pred_q;                      // Guess made for the branch in flight.
    logic [31:0] fall_q;                      // Fall-through of that branch.
    logic        mispredict;

    assign pc_plus4 = pc_q + 32'd4;

    // The branch fetched last cycle resolves now, so compare against the record.
    assign mispredict = resolve_i.valid && (resolve_i.taken != pred_q);

    assign flush_o = mispredict;
    assign pc_o    = pc_q;

    always_comb begin
        if (mispredict) begin
            if (resolve_i.taken) begin
                pc_next = resolve_i.target;   // Missed a taken branch.
            end else begin
                pc_next = fall_q;             // Wrongly guessed taken.
            end
        end else if (stall_i) begin
            pc_next = pc_q;
        end else if (jump_i) begin
            pc_next = jump_target_i;
        end else if (branch_fetch_i && predict_taken_i) begin
            pc_next = fetch_target_i;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q   <= steer_pkg::RESET_PC;
            pred_q <= 1'b0;
        end else begin
            pc_q <= pc_next;
            if (!stall_i) begin
                pred_q <= branch_fetch_i && predict_taken_i;
            end
        end
    end

    // Fall-through of the last fetch that was not stalled.
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            fall_q <= pc_plus4;
        end
    end

endmodule

// File: design/steer_pkg.sv
package steer_pkg;

    localparam logic [31:0] RESET_PC = 32'h4000_0000;       // Boot ROM entry.

    // Top nibble of a memory load address.
    localparam logic [3:0] REGION_DMEM_A = 4'h1;
    localparam logic [3:0] REGION_DMEM_B = 4'h3;
    localparam logic [3:0] REGION_BIOS   = 4'h4;

    localparam logic [31:0] UART_CTRL_ADDR  = 32'h8000_0000;
    localparam logic [31:0] UART_RX_ADDR    = 32'h8000_0004;
    localparam logic [31:0] UART_CYCLE_ADDR = 32'h8000_0010;
    localparam logic [31:0] UART_INST_ADDR  = 32'h8000_0014;
    localparam logic [31:0] CONV_READ_ADDR  = 32'h8000_0020; // Accelerator result.

    typedef enum logic [1:0] {
        LD_IO  = 2'b01,                                      // Peripheral read.
        LD_MEM = 2'b10                                       // RAM or ROM load.
    } ld_kind_e;

    // ALT is the PC for operand A and the immediate for operand B.
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_ALT = 2'b10
    } fwd_sel_e;

    typedef enum logic [2:0] {
        RET_NONE = 3'd0,
        RET_DMEM = 3'd1,
        RET_BIOS = 3'd2,
        RET_UART = 3'd3,
        RET_CONV = 3'd4
    } ret_src_e;

    typedef struct packed {
        logic        valid;
        ld_kind_e    kind;
        logic [31:0] addr;
    } load_req_t;

    typedef struct packed {
        logic [31:0] dmem;
        logic [31:0] bios;
        logic [31:0] uart;
        logic [31:0] conv;
    } read_data_t;

    typedef struct packed {
        logic        valid;
        logic        taken;
        logic [31:0] target;
    } resolve_t;

    typedef struct packed {
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] wb;
        logic [31:0] pc;
        logic [31:0] imm;
        fwd_sel_e    sel_a;
        fwd_sel_e    sel_b;
    } operand_src_t;

endpackage
